// File: Bender.yml
package:
  name: full_decoder

sources:
  - rv_isa_pkg.sv
  - decode_ctrl_pkg.sv
  - mem_flow_decoder.sv
  - int_op_decoder.sv
  - system_decoder.sv
  - full_decoder.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_full_decoder.sv

// File: decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

   typedef logic [3:0] alu_op_t;
   typedef logic [2:0] mdu_op_t;
   typedef logic [3:0] exc_cause_t;
   typedef logic [1:0] unit_sel_t;
   typedef logic [1:0] csr_op_t;
   typedef logic [1:0] wb_sel_t;
   typedef logic [1:0] mem_data_sel_t;

   // ALU codes 2 and 11 are not decoded
   localparam alu_op_t ALU_ADD    = 4'd0;
   localparam alu_op_t ALU_SUB    = 4'd1;
   localparam alu_op_t ALU_SLL    = 4'd3;
   localparam alu_op_t ALU_SLT    = 4'd4;
   localparam alu_op_t ALU_SLTU   = 4'd5;
   localparam alu_op_t ALU_XOR    = 4'd6;
   localparam alu_op_t ALU_SRL    = 4'd7;
   localparam alu_op_t ALU_SRA    = 4'd8;
   localparam alu_op_t ALU_OR     = 4'd9;
   localparam alu_op_t ALU_AND    = 4'd10;
   localparam alu_op_t ALU_PASS_B = 4'd12;

   localparam exc_cause_t EXC_INSTR_MISALIGN = 4'd0;
   localparam exc_cause_t EXC_ILLEGAL        = 4'd2;
   localparam exc_cause_t EXC_BREAKPOINT     = 4'd3;
   localparam exc_cause_t EXC_LOAD_FAULT     = 4'd4;
   localparam exc_cause_t EXC_STORE_FAULT    = 4'd6;
   localparam exc_cause_t EXC_ECALL_M        = 4'd11;

   localparam unit_sel_t UNIT_ALU = 2'd0;
   localparam unit_sel_t UNIT_MDU = 2'd1;
   // Kept reserved for a bit-manipulation unit
   localparam unit_sel_t UNIT_BMU = 2'd2;
   localparam unit_sel_t UNIT_CSR = 2'd3;

   localparam csr_op_t CSR_NONE  = 2'd0;
   localparam csr_op_t CSR_WRITE = 2'd1;
   localparam csr_op_t CSR_SET   = 2'd2;
   localparam csr_op_t CSR_CLEAR = 2'd3;

   localparam wb_sel_t WB_EXEC    = 2'd0;
   localparam wb_sel_t WB_MEM     = 2'd1;
   localparam wb_sel_t WB_PC_LINK = 2'd3;

   localparam mem_data_sel_t MEMD_KEEP = 2'd0;
   localparam mem_data_sel_t MEMD_LOAD = 2'd1;

   // Cause is also the fault that a later stage may raise
   typedef struct packed {
      logic       exception_detected;
      exc_cause_t cause;
      logic       is_mret;
   } exc_ctrl_t;

   typedef struct packed {
      unit_sel_t unit;
      alu_op_t   alu_op;
      logic      mdu_en;
      mdu_op_t   mdu_op;
      logic      rs2_negate;
      logic      csr_en;
      csr_op_t   csr_op;
      logic      csr_imm;
   } exec_ctrl_t;

   typedef struct packed {
      logic    reg_wr_en;
      wb_sel_t wb_sel;
   } wb_ctrl_t;

   typedef struct packed {
      logic          op1_pc;
      logic          op2_imm;
      logic          is_load;
      logic          is_store;
      mem_data_sel_t data_sel;
   } mem_ctrl_t;

   typedef struct packed {
      exc_ctrl_t  exc;
      exec_ctrl_t exec;
      wb_ctrl_t   wb;
      mem_ctrl_t  mem;
   } decode_ctrl_t;

   localparam decode_ctrl_t CTRL_ILLEGAL = '{
      exc: '{exception_detected: 1'b1, cause: EXC_ILLEGAL, is_mret: 1'b0},
      exec: '0,
      wb: '0,
      mem: '0
   };

endpackage

`default_nettype wire

// File: full_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module full_decoder (
   input  rv_isa_pkg::instr_t          instr_i,
   input  logic                        is_m_supported_i,
   output decode_ctrl_pkg::exc_ctrl_t  exc_o,
   output decode_ctrl_pkg::exec_ctrl_t exec_o,
   output decode_ctrl_pkg::wb_ctrl_t   wb_o,
   output decode_ctrl_pkg::mem_ctrl_t  mem_o
);
   import decode_ctrl_pkg::*;

   logic         mem_match;
   logic         int_match;
   logic         sys_match;
   decode_ctrl_t mem_ctrl;
   decode_ctrl_t int_ctrl;
   decode_ctrl_t sys_ctrl;
   decode_ctrl_t sel_ctrl;

   mem_flow_decoder u_mem_flow_decoder (
      .instr_i (instr_i),
      .match_o (mem_match),
      .ctrl_o  (mem_ctrl)
   );

   int_op_decoder u_int_op_decoder (
      .instr_i          (instr_i),
      .is_m_supported_i (is_m_supported_i),
      .match_o          (int_match),
      .ctrl_o           (int_ctrl)
   );

   system_decoder u_system_decoder (
      .instr_i (instr_i),
      .match_o (sys_match),
      .ctrl_o  (sys_ctrl)
   );

   // Opcode sets are disjoint so at most one match is high
   always_comb begin
      if (mem_match) begin
         sel_ctrl = mem_ctrl;
      end else if (int_match) begin
         sel_ctrl = int_ctrl;
      end else if (sys_match) begin
         sel_ctrl = sys_ctrl;
      end else begin
         sel_ctrl = CTRL_ILLEGAL;
      end
   end

   assign exc_o  = sel_ctrl.exc;
   assign exec_o = sel_ctrl.exec;
   assign wb_o   = sel_ctrl.wb;
   assign mem_o  = sel_ctrl.mem;

endmodule

`default_nettype wire

// File: int_op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module int_op_decoder (
   input  rv_isa_pkg::instr_t           instr_i,
   input  logic                         is_m_supported_i,
   output logic                         match_o,
   output decode_ctrl_pkg::decode_ctrl_t ctrl_o
);
   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   opcode_t      opcode;
   funct3_t      funct3;
   funct7_t      funct7;
   logic         hit;
   decode_ctrl_t ctrl;

   assign opcode = instr_i[6:2];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // Base ALU code per funct3 before the alternate forms are applied
   function automatic alu_op_t base_alu_op(input funct3_t f3);
      alu_op_t op;
      case (f3)
         F3_ADD:  op = ALU_ADD;
         F3_SLL:  op = ALU_SLL;
         F3_SLT:  op = ALU_SLT;
         F3_SLTU: op = ALU_SLTU;
         F3_XOR:  op = ALU_XOR;
         F3_SR:   op = ALU_SRL;
         F3_OR:   op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb begin
      hit  = 1'b0;
      ctrl = '0;
      ctrl.wb.reg_wr_en = 1'b1;
      ctrl.wb.wb_sel    = WB_EXEC;
      case (opcode)
         OPC_OP_IMM: begin
            ctrl.exec.alu_op = base_alu_op(funct3);
            ctrl.mem.op2_imm = 1'b1;
            case (funct3)
               F3_SLL: hit = (funct7 == F7_BASE);
               F3_SR: begin
                  hit = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                  if (funct7 == F7_ALT) begin
                     ctrl.exec.alu_op = ALU_SRA;
                  end
               end
               default: hit = 1'b1;
            endcase
         end
         OPC_OP: begin
            case (funct7)
               F7_BASE: begin
                  hit              = 1'b1;
                  ctrl.exec.alu_op = base_alu_op(funct3);
               end
               F7_ALT: begin
                  // Only SUB and SRA have an alternate form
                  if (funct3 == F3_ADD) begin
                     hit                  = 1'b1;
                     ctrl.exec.alu_op     = ALU_SUB;
                     ctrl.exec.rs2_negate = 1'b1;
                  end else if (funct3 == F3_SR) begin
                     hit              = 1'b1;
                     ctrl.exec.alu_op = ALU_SRA;
                  end
               end
               F7_MULDIV: begin
                  hit              = is_m_supported_i;
                  ctrl.exec.unit   = UNIT_MDU;
                  ctrl.exec.mdu_en = 1'b1;
                  ctrl.exec.mdu_op = funct3;
               end
               default: hit = 1'b0;
            endcase
         end
         default: hit = 1'b0;
      endcase
   end

   // Bundle stays zero unless the encoding is recognized
   assign match_o = hit;
   assign ctrl_o  = hit ? ctrl : '0;

endmodule

`default_nettype wire

// File: mem_flow_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_flow_decoder (
   input  rv_isa_pkg::instr_t           instr_i,
   output logic                         match_o,
   output decode_ctrl_pkg::decode_ctrl_t ctrl_o
);
   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   opcode_t opcode;
   funct3_t funct3;

   assign opcode = instr_i[6:2];
   assign funct3 = instr_i[14:12];

   always_comb begin
      match_o = 1'b0;
      ctrl_o  = '0;
      case (opcode)
         OPC_LOAD: begin
            if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
               match_o                = 1'b1;
               ctrl_o.exc.cause       = EXC_LOAD_FAULT;
               ctrl_o.wb.reg_wr_en    = 1'b1;
               ctrl_o.wb.wb_sel       = WB_MEM;
               ctrl_o.mem.op2_imm     = 1'b1;
               ctrl_o.mem.is_load     = 1'b1;
               ctrl_o.mem.data_sel    = MEMD_LOAD;
            end
         end
         OPC_STORE: begin
            if (funct3 inside {F3_SB, F3_SH, F3_SW}) begin
               match_o                = 1'b1;
               ctrl_o.exc.cause       = EXC_STORE_FAULT;
               ctrl_o.mem.op2_imm     = 1'b1;
               ctrl_o.mem.is_store    = 1'b1;
               ctrl_o.mem.data_sel    = MEMD_KEEP;
            end
         end
         OPC_BRANCH: begin
            if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
               match_o                = 1'b1;
               ctrl_o.exc.cause       = EXC_INSTR_MISALIGN;
               ctrl_o.mem.op1_pc      = 1'b1;
               ctrl_o.mem.op2_imm     = 1'b1;
            end
         end
         OPC_JAL, OPC_JALR: begin
            // JALR adds to rs1, JAL to the PC
            if (opcode == OPC_JAL || funct3 == F3_JALR) begin
               match_o                = 1'b1;
               ctrl_o.exc.cause       = EXC_INSTR_MISALIGN;
               ctrl_o.wb.reg_wr_en    = 1'b1;
               ctrl_o.wb.wb_sel       = WB_PC_LINK;
               ctrl_o.mem.op1_pc      = (opcode == OPC_JAL);
               ctrl_o.mem.op2_imm     = 1'b1;
            end
         end
         OPC_LUI, OPC_AUIPC: begin
            match_o                   = 1'b1;
            ctrl_o.exec.alu_op        = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
            ctrl_o.wb.reg_wr_en       = 1'b1;
            ctrl_o.wb.wb_sel          = WB_EXEC;
            ctrl_o.mem.op1_pc         = (opcode == OPC_AUIPC);
            ctrl_o.mem.op2_imm        = 1'b1;
         end
         default: begin
            match_o = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   // Decode input carries instruction bits [31:2]
   typedef logic [31:2] instr_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;
   typedef logic [11:0] funct12_t;
   typedef logic [4:0]  reg_idx_t;

   // Major opcodes, instruction bits [6:2]
   localparam opcode_t OPC_LOAD   = 5'b00000;
   localparam opcode_t OPC_OP_IMM = 5'b00100;
   localparam opcode_t OPC_AUIPC  = 5'b00101;
   localparam opcode_t OPC_STORE  = 5'b01000;
   localparam opcode_t OPC_OP     = 5'b01100;
   localparam opcode_t OPC_LUI    = 5'b01101;
   localparam opcode_t OPC_BRANCH = 5'b11000;
   localparam opcode_t OPC_JALR   = 5'b11001;
   localparam opcode_t OPC_JAL    = 5'b11011;
   localparam opcode_t OPC_SYSTEM = 5'b11100;

   localparam funct7_t F7_BASE   = 7'b0000000;
   localparam funct7_t F7_ALT    = 7'b0100000;
   localparam funct7_t F7_MULDIV = 7'b0000001;

   localparam funct3_t F3_LB  = 3'b000;
   localparam funct3_t F3_LH  = 3'b001;
   localparam funct3_t F3_LW  = 3'b010;
   localparam funct3_t F3_LBU = 3'b100;
   localparam funct3_t F3_LHU = 3'b101;

   localparam funct3_t F3_SB = 3'b000;
   localparam funct3_t F3_SH = 3'b001;
   localparam funct3_t F3_SW = 3'b010;

   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   localparam funct3_t F3_BLT  = 3'b100;
   localparam funct3_t F3_BGE  = 3'b101;
   localparam funct3_t F3_BLTU = 3'b110;
   localparam funct3_t F3_BGEU = 3'b111;

   localparam funct3_t F3_JALR = 3'b000;

   // Shared by OP-IMM and OP where funct7 picks the shift and add variants
   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_SLL  = 3'b001;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_SLTU = 3'b011;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_SR   = 3'b101;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;

   localparam funct3_t F3_MUL    = 3'b000;
   localparam funct3_t F3_MULH   = 3'b001;
   localparam funct3_t F3_MULHSU = 3'b010;
   localparam funct3_t F3_MULHU  = 3'b011;
   localparam funct3_t F3_DIV    = 3'b100;
   localparam funct3_t F3_DIVU   = 3'b101;
   localparam funct3_t F3_REM    = 3'b110;
   localparam funct3_t F3_REMU   = 3'b111;

   localparam funct3_t F3_PRIV   = 3'b000;
   localparam funct3_t F3_CSRRW  = 3'b001;
   localparam funct3_t F3_CSRRS  = 3'b010;
   localparam funct3_t F3_CSRRC  = 3'b011;
   localparam funct3_t F3_CSRRWI = 3'b101;
   localparam funct3_t F3_CSRRSI = 3'b110;
   localparam funct3_t F3_CSRRCI = 3'b111;

   localparam funct12_t F12_ECALL  = 12'b0000000_00000;
   localparam funct12_t F12_EBREAK = 12'b0000000_00001;
   localparam funct12_t F12_MRET   = 12'b0011000_00010;
   localparam funct12_t F12_WFI    = 12'b0001000_00101;

endpackage

`default_nettype wire

// File: sim.f
+incdir+.
rv_isa_pkg.sv
decode_ctrl_pkg.sv
mem_flow_decoder.sv
int_op_decoder.sv
system_decoder.sv
full_decoder.sv
tb_full_decoder.sv

// File: system_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module system_decoder (
   input  rv_isa_pkg::instr_t           instr_i,
   output logic                         match_o,
   output decode_ctrl_pkg::decode_ctrl_t ctrl_o
);
   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   opcode_t  opcode;
   funct3_t  funct3;
   funct12_t funct12;
   reg_idx_t rd;
   reg_idx_t rs1;

   assign opcode  = instr_i[6:2];
   assign funct3  = instr_i[14:12];
   assign funct12 = instr_i[31:20];
   assign rd      = instr_i[11:7];
   assign rs1     = instr_i[19:15];

   always_comb begin
      match_o = 1'b0;
      ctrl_o  = '0;
      if (opcode == OPC_SYSTEM) begin
         case (funct3)
            F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: begin
               match_o             = 1'b1;
               ctrl_o.exec.unit    = UNIT_CSR;
               ctrl_o.exec.csr_en  = 1'b1;
               // funct3 low bits already follow the write/set/clear order
               ctrl_o.exec.csr_op  = funct3[1:0];
               ctrl_o.exec.csr_imm = funct3[2];
               ctrl_o.wb.reg_wr_en = 1'b1;
               ctrl_o.wb.wb_sel    = WB_EXEC;
            end
            F3_PRIV: begin
               if (rd == '0 && rs1 == '0) begin
                  case (funct12)
                     F12_ECALL: begin
                        match_o                       = 1'b1;
                        ctrl_o.exc.exception_detected = 1'b1;
                        ctrl_o.exc.cause              = EXC_ECALL_M;
                     end
                     F12_EBREAK: begin
                        match_o                       = 1'b1;
                        ctrl_o.exc.exception_detected = 1'b1;
                        ctrl_o.exc.cause              = EXC_BREAKPOINT;
                     end
                     F12_MRET: begin
                        match_o            = 1'b1;
                        ctrl_o.exc.is_mret = 1'b1;
                     end
                     // WFI runs as a NOP
                     F12_WFI: match_o = 1'b1;
                     default: match_o = 1'b0;
                  endcase
               end
            end
            default: match_o = 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tb_decode_ref.svh
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// ALU code of each funct3 for the base OP and OP-IMM forms
localparam alu_op_t ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                      ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

function automatic decode_ctrl_t decode_ref(input instr_t instr, input logic m_sup);
   decode_ctrl_t c;
   logic         ok;
   opcode_t      opc;
   funct3_t      f3;
   funct7_t      f7;
   logic         priv_regs_zero;
   c              = '0;
   ok             = 1'b0;
   opc            = instr[6:2];
   f3             = instr[14:12];
   f7             = instr[31:25];
   priv_regs_zero = (instr[11:7] == 5'd0) && (instr[19:15] == 5'd0);
   case (opc)
      OPC_LOAD: begin
         ok          = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
         c.exc.cause = EXC_LOAD_FAULT;
         c.wb        = '{reg_wr_en: 1'b1, wb_sel: WB_MEM};
         c.mem       = '{op1_pc: 1'b0, op2_imm: 1'b1, is_load: 1'b1, is_store: 1'b0,
                         data_sel: MEMD_LOAD};
      end
      OPC_STORE: begin
         ok             = (f3 <= 3'd2);
         c.exc.cause    = EXC_STORE_FAULT;
         c.mem.op2_imm  = 1'b1;
         c.mem.is_store = 1'b1;
      end
      OPC_BRANCH: begin
         ok            = (f3 != 3'd2) && (f3 != 3'd3);
         c.exc.cause   = EXC_INSTR_MISALIGN;
         c.mem.op1_pc  = 1'b1;
         c.mem.op2_imm = 1'b1;
      end
      OPC_JAL: begin
         ok            = 1'b1;
         c.exc.cause   = EXC_INSTR_MISALIGN;
         c.wb          = '{reg_wr_en: 1'b1, wb_sel: WB_PC_LINK};
         c.mem.op1_pc  = 1'b1;
         c.mem.op2_imm = 1'b1;
      end
      OPC_JALR: begin
         ok            = (f3 == 3'd0);
         c.exc.cause   = EXC_INSTR_MISALIGN;
         c.wb          = '{reg_wr_en: 1'b1, wb_sel: WB_PC_LINK};
         c.mem.op2_imm = 1'b1;
      end
      OPC_LUI: begin
         ok             = 1'b1;
         c.exec.alu_op  = ALU_PASS_B;
         c.wb.reg_wr_en = 1'b1;
         c.mem.op2_imm  = 1'b1;
      end
      OPC_AUIPC: begin
         ok             = 1'b1;
         c.exec.alu_op  = ALU_ADD;
         c.wb.reg_wr_en = 1'b1;
         c.mem.op1_pc   = 1'b1;
         c.mem.op2_imm  = 1'b1;
      end
      OPC_OP_IMM: begin
         c.exec.alu_op  = ALU_BY_F3[f3];
         c.wb.reg_wr_en = 1'b1;
         c.mem.op2_imm  = 1'b1;
         // Shift immediates keep funct7 as an encoding field
         if (f3 == 3'd1) begin
            ok = (f7 == F7_BASE);
         end else if (f3 == 3'd5) begin
            ok = (f7 == F7_BASE) || (f7 == F7_ALT);
            if (f7 == F7_ALT) begin
               c.exec.alu_op = ALU_SRA;
            end
         end else begin
            ok = 1'b1;
         end
      end
      OPC_OP: begin
         c.wb.reg_wr_en = 1'b1;
         if (f7 == F7_BASE) begin
            ok            = 1'b1;
            c.exec.alu_op = ALU_BY_F3[f3];
         end else if (f7 == F7_ALT) begin
            ok                = (f3 == 3'd0) || (f3 == 3'd5);
            c.exec.alu_op     = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
            c.exec.rs2_negate = (f3 == 3'd0);
         end else if (f7 == F7_MULDIV) begin
            ok            = m_sup;
            c.exec.unit   = UNIT_MDU;
            c.exec.mdu_en = 1'b1;
            c.exec.mdu_op = f3;
         end
      end
      OPC_SYSTEM: begin
         if (f3[1:0] != 2'b00) begin
            ok             = 1'b1;
            c.exec.unit    = UNIT_CSR;
            c.exec.csr_en  = 1'b1;
            case (f3[1:0])
               2'd1:    c.exec.csr_op = CSR_WRITE;
               2'd2:    c.exec.csr_op = CSR_SET;
               default: c.exec.csr_op = CSR_CLEAR;
            endcase
            c.exec.csr_imm = f3[2];
            c.wb.reg_wr_en = 1'b1;
         end else if (f3 == 3'd0 && priv_regs_zero) begin
            case (instr[31:20])
               F12_ECALL: begin
                  ok    = 1'b1;
                  c.exc = '{exception_detected: 1'b1, cause: EXC_ECALL_M, is_mret: 1'b0};
               end
               F12_EBREAK: begin
                  ok    = 1'b1;
                  c.exc = '{exception_detected: 1'b1, cause: EXC_BREAKPOINT, is_mret: 1'b0};
               end
               F12_MRET: begin
                  ok            = 1'b1;
                  c.exc.is_mret = 1'b1;
               end
               F12_WFI: ok = 1'b1;
               default: ok = 1'b0;
            endcase
         end
      end
      default: ok = 1'b0;
   endcase
   return ok ? c : CTRL_ILLEGAL;
endfunction

`endif

// File: tb_full_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_full_decoder;
   import rv_isa_pkg::*;
   import decode_ctrl_pkg::*;

   `include "tb_decode_ref.svh"

   localparam opcode_t MEM_OPCODES [7] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL,
                                           OPC_JALR, OPC_LUI, OPC_AUIPC};
   localparam funct12_t PRIV_F12 [4] = '{F12_ECALL, F12_EBREAK, F12_MRET, F12_WFI};
   localparam funct7_t BAD_F7 = 7'b0010000;

   logic       clk;
   logic       rst_n_i;
   instr_t     instr_i;
   logic       is_m_supported_i;
   exc_ctrl_t  exc_o;
   exec_ctrl_t exec_o;
   wb_ctrl_t   wb_o;
   mem_ctrl_t  mem_o;

   string      test_name;
   int         applied_count;
   int         checked_count;
   int         error_count;
   int         test_count;
   int         test_errors_start;
   int         test_vectors_start;

   full_decoder dut (
      .instr_i          (instr_i),
      .is_m_supported_i (is_m_supported_i),
      .exc_o            (exc_o),
      .exec_o           (exec_o),
      .wb_o             (wb_o),
      .mem_o            (mem_o)
   );

   always #5 clk = ~clk;

   task automatic check_exc(input exc_ctrl_t exp, input exc_ctrl_t act);
      if (act !== exp) begin
         $display("MISMATCH %s exc expected %h actual %h", test_name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_exec(input exec_ctrl_t exp, input exec_ctrl_t act);
      if (act !== exp) begin
         $display("MISMATCH %s exec expected %h actual %h", test_name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_wb(input wb_ctrl_t exp, input wb_ctrl_t act);
      if (act !== exp) begin
         $display("MISMATCH %s wb expected %h actual %h", test_name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_mem(input mem_ctrl_t exp, input mem_ctrl_t act);
      if (act !== exp) begin
         $display("MISMATCH %s mem expected %h actual %h", test_name, exp, act);
         error_count++;
      end
   endtask

   // One check per applied word at mid-cycle
   always @(negedge clk) begin
      decode_ctrl_t expected;
      if (rst_n_i && checked_count < applied_count) begin
         expected = decode_ref(instr_i, is_m_supported_i);
         check_exc(expected.exc, exc_o);
         check_exec(expected.exec, exec_o);
         check_wb(expected.wb, wb_o);
         check_mem(expected.mem, mem_o);
         checked_count++;
      end
   end

   function automatic logic [31:0] field_word(input opcode_t opc, input funct3_t f3);
      logic [31:0] w;
      w        = $urandom;
      w[1:0]   = 2'b11;
      w[6:2]   = opc;
      w[14:12] = f3;
      return w;
   endfunction

   task automatic drive_word(input logic [31:0] word, input logic m_sup);
      @(posedge clk);
      #1;
      instr_i          = word[31:2];
      is_m_supported_i = m_sup;
      applied_count++;
   endtask

   task automatic start_test(input string name);
      test_name          = name;
      test_errors_start  = error_count;
      test_vectors_start = applied_count;
   endtask

   task automatic end_test();
      int wait_cycles;
      wait_cycles = 0;
      while (checked_count < applied_count && wait_cycles < 10) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (checked_count < applied_count) begin
         $display("ERROR %s: %0d words were never checked", test_name,
                  applied_count - checked_count);
         error_count++;
      end
      test_count++;
      $display("%s done: %0d words, %0d errors", test_name,
               applied_count - test_vectors_start, error_count - test_errors_start);
   endtask

   initial begin
      logic [31:0] word;
      void'($urandom(32'h8da7_1197));
      clk              = 1'b0;
      rst_n_i          = 1'b0;
      instr_i          = '0;
      is_m_supported_i = 1'b0;
      applied_count    = 0;
      checked_count    = 0;
      error_count      = 0;
      test_count       = 0;
      test_name        = "reset";
      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
      end
      #1;
      rst_n_i = 1'b1;

      // Every funct3 brings in the illegal load, store and JALR forms too
      start_test("mem_flow");
      foreach (MEM_OPCODES[k]) begin
         for (int f = 0; f < 8; f++) begin
            for (int r = 0; r < 4; r++) begin
               drive_word(field_word(MEM_OPCODES[k], funct3_t'(f)), 1'($urandom % 2));
            end
         end
      end
      end_test();

      start_test("int_alu");
      for (int f = 0; f < 8; f++) begin
         for (int v = 0; v < 3; v++) begin
            word        = field_word(OPC_OP_IMM, funct3_t'(f));
            word[31:25] = (v == 0) ? F7_BASE : ((v == 1) ? F7_ALT : BAD_F7);
            drive_word(word, 1'b1);
            word[6:2] = OPC_OP;
            drive_word(word, 1'b1);
         end
      end
      end_test();

      start_test("muldiv");
      for (int f = 0; f < 8; f++) begin
         for (int m = 0; m < 2; m++) begin
            word        = field_word(OPC_OP, funct3_t'(f));
            word[31:25] = F7_MULDIV;
            drive_word(word, 1'(m));
         end
      end
      end_test();

      start_test("system");
      for (int f = 0; f < 8; f++) begin
         for (int r = 0; r < 4; r++) begin
            drive_word(field_word(OPC_SYSTEM, funct3_t'(f)), 1'b1);
         end
      end
      for (int p = 0; p < 4; p++) begin
         for (int v = 0; v < 3; v++) begin
            word = {PRIV_F12[p], 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM, 2'b11};
            if (v == 1) begin
               word[11:7] = 5'($urandom % 31 + 1);
            end else if (v == 2) begin
               word[19:15] = 5'($urandom % 31 + 1);
            end
            drive_word(word, 1'b1);
         end
      end
      end_test();

      start_test("opcode_sweep");
      for (int o = 0; o < 32; o++) begin
         for (int r = 0; r < 4; r++) begin
            drive_word(field_word(opcode_t'(o), funct3_t'($urandom)), 1'($urandom % 2));
         end
      end
      end_test();

      start_test("random_sweep");
      for (int n = 0; n < 2000; n++) begin
         drive_word($urandom, 1'($urandom % 2));
      end
      end_test();

      $display("Tests %0d, words checked %0d, errors %0d", test_count, checked_count,
               error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      #500_000;
      $display("Run did not finish within the time limit");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire
